/* logic/mem_bus_pkg.sv */
package mem_bus_pkg;

  // memory geometry
  localparam int WORD_W     = 32;
  localparam int BE_W       = WORD_W / 8;
  localparam int MEM_WORDS  = 256;
  localparam int MEM_ADDR_W = $clog2(MEM_WORDS);  // word index, 8 bits

  // first byte address that maps onto word 0 of the sram
  localparam logic [31:0] DMEM_BASE = 32'h0001_0000;

  // request from a master toward the memory port
  // held stable by the master until it sees gnt
  typedef struct packed {
    logic              valid;
    logic [31:0]       addr;   // byte address, base not yet removed
    logic              we;
    logic [BE_W-1:0]   be;     // byte enables, all set for reads
    logic [WORD_W-1:0] wdata;  // already steered to its lanes
  } mem_req_t;

  // response back to the master
  // gnt in the request cycle, rvalid one cycle after it
  typedef struct packed {
    logic              gnt;
    logic              rvalid;
    logic [WORD_W-1:0] rdata;  // word after the access, writes included
  } mem_rsp_t;

endpackage

/* logic/lsu_pkg.sv */
package lsu_pkg;

  // decoded memory operation as it leaves the pipeline
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_LB   = 4'd1,
    OP_LH   = 4'd2,
    OP_LW   = 4'd3,
    OP_LBU  = 4'd4,
    OP_LHU  = 4'd5,
    OP_SB   = 4'd6,
    OP_SH   = 4'd7,
    OP_SW   = 4'd8
  } lsu_op_e;

  // one load or store, held by the pipeline while stall is up
  typedef struct packed {
    lsu_op_e     op;
    logic [31:0] addr;   // full byte address, rs1 + imm
    logic [31:0] wdata;  // rs2, unsteered
  } lsu_cmd_t;

endpackage

/* logic/lsu_core.sv */
`timescale 1ns/1ps

module lsu_core
  import mem_bus_pkg::*;
  import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  lsu_cmd_t    cmd_i,
  output logic        stall_o,
  output logic        load_done_o,
  output logic [31:0] load_data_o,
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT_GNT,
    S_WAIT_RV
  } state_e;

  state_e            state_q, state_d;
  logic              is_load, is_store;
  logic              req_valid;
  logic [1:0]        off;
  logic [BE_W-1:0]   st_be;
  logic [WORD_W-1:0] st_data;
  lsu_op_e           op_q;   // op of the access in flight
  logic [1:0]        off_q;
  logic [7:0]        ld_byte;
  logic [15:0]       ld_half;

  function automatic logic is_load_op(lsu_op_e op);
    return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
  endfunction

  assign is_load  = is_load_op(cmd_i.op);
  assign is_store = cmd_i.op inside {OP_SB, OP_SH, OP_SW};
  assign off      = cmd_i.addr[1:0];

  // store lane steering, byte enables follow the low address bits
  always_comb begin
    st_be   = '0;
    st_data = cmd_i.wdata;
    case (cmd_i.op)
      OP_SB: begin
        st_be   = 4'b0001 << off;
        st_data = {24'b0, cmd_i.wdata[7:0]} << {off, 3'b000};
      end
      OP_SH: begin
        st_be   = off[1] ? 4'b1100 : 4'b0011;
        st_data = off[1] ? {cmd_i.wdata[15:0], 16'b0} : {16'b0, cmd_i.wdata[15:0]};
      end
      OP_SW:   st_be = 4'b1111;
      default: st_be = '0;
    endcase
  end

  // request fsm, one access at a time
  always_comb begin
    state_d   = state_q;
    req_valid = 1'b0;
    stall_o   = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (is_load || is_store) begin
          req_valid = 1'b1;
          stall_o   = 1'b1;
          state_d   = mem_rsp_i.gnt ? S_WAIT_RV : S_WAIT_GNT;
        end
      end
      S_WAIT_GNT: begin
        req_valid = 1'b1;  // lost arbitration, keep asking
        stall_o   = 1'b1;
        if (mem_rsp_i.gnt) state_d = S_WAIT_RV;
      end
      S_WAIT_RV: begin
        if (mem_rsp_i.rvalid) state_d = S_IDLE;
        else                  stall_o = 1'b1;
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state_q <= S_IDLE;
    else       state_q <= state_d;
  end

  // remember what was granted, used to pick lanes on return
  always_ff @(posedge clk) begin
    if (req_valid && mem_rsp_i.gnt) begin
      op_q  <= cmd_i.op;
      off_q <= cmd_i.addr[1:0];
    end
  end

  assign mem_req_o.valid = req_valid;
  assign mem_req_o.addr  = cmd_i.addr;
  assign mem_req_o.we    = is_store;
  assign mem_req_o.be    = is_store ? st_be : 4'b1111;  // loads read the whole word
  assign mem_req_o.wdata = st_data;

  // load extraction and extension
  assign ld_byte = 8'(mem_rsp_i.rdata >> {off_q, 3'b000});
  assign ld_half = off_q[1] ? mem_rsp_i.rdata[31:16] : mem_rsp_i.rdata[15:0];

  always_comb begin
    case (op_q)
      OP_LB:   load_data_o = {{24{ld_byte[7]}}, ld_byte};
      OP_LH:   load_data_o = {{16{ld_half[15]}}, ld_half};
      OP_LBU:  load_data_o = {24'b0, ld_byte};
      OP_LHU:  load_data_o = {16'b0, ld_half};
      default: load_data_o = mem_rsp_i.rdata;  // lw
    endcase
  end

  assign load_done_o = (state_q == S_WAIT_RV) && mem_rsp_i.rvalid && is_load_op(op_q);

  // a taken access is answered on the very next cycle
  a_rvalid_after_gnt: assert property (@(posedge clk) disable iff (reset)
    (mem_req_o.valid && mem_rsp_i.gnt) |=> mem_rsp_i.rvalid);

endmodule

/* logic/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit
  import mem_bus_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        fetch_en_i,
  output logic        instr_valid_o,
  output logic [31:0] instr_o,
  output logic [31:0] instr_pc_o,
  output mem_req_t    mem_req_o,
  input  mem_rsp_t    mem_rsp_i
);

  logic [31:0] pc_q;
  logic        waiting_q;  // granted, read-valid still to come
  logic        held_q;     // request raised but not yet granted
  logic        req_valid;

  // a raised request stays up until granted, even if enable drops
  assign req_valid = !waiting_q && (fetch_en_i || held_q);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q      <= DMEM_BASE;
      waiting_q <= 1'b0;
      held_q    <= 1'b0;
    end else begin
      held_q <= req_valid && !mem_rsp_i.gnt;
      if (req_valid && mem_rsp_i.gnt) waiting_q <= 1'b1;
      else if (mem_rsp_i.rvalid)      waiting_q <= 1'b0;
      if (mem_rsp_i.rvalid) pc_q <= pc_q + 32'd4;  // sequential only
    end
  end

  assign mem_req_o.valid = req_valid;
  assign mem_req_o.addr  = pc_q;
  assign mem_req_o.we    = 1'b0;
  assign mem_req_o.be    = '1;
  assign mem_req_o.wdata = '0;

  assign instr_valid_o = mem_rsp_i.rvalid;
  assign instr_o       = mem_rsp_i.rdata;
  assign instr_pc_o    = pc_q;  // pc advances only after this word

  // the arbiter must only steer read-valid here for our own access
  a_rvalid_when_waiting: assert property (@(posedge clk) disable iff (reset)
    mem_rsp_i.rvalid |-> waiting_q);

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps

module mem_arbiter
  import mem_bus_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  mem_req_t data_req_i,
  input  mem_req_t fetch_req_i,
  output mem_rsp_t data_rsp_o,
  output mem_rsp_t fetch_rsp_o,
  output mem_req_t mem_req_o,
  input  mem_rsp_t mem_rsp_i
);

  logic data_win;
  logic granted;
  logic owner_q;  // 1 = fetch owns the pending read-valid

  // data side has fixed priority
  assign data_win  = data_req_i.valid;
  assign mem_req_o = data_win ? data_req_i : fetch_req_i;
  assign granted   = mem_req_o.valid && mem_rsp_i.gnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      owner_q <= 1'b0;
    end else if (granted) begin
      owner_q <= !data_win;
    end
  end

  // grant goes to the winner only, the loser keeps its request held
  always_comb begin
    data_rsp_o.gnt     = mem_rsp_i.gnt && data_win;
    data_rsp_o.rvalid  = mem_rsp_i.rvalid && !owner_q;
    data_rsp_o.rdata   = owner_q ? '0 : mem_rsp_i.rdata;

    fetch_rsp_o.gnt    = mem_rsp_i.gnt && !data_win && fetch_req_i.valid;
    fetch_rsp_o.rvalid = mem_rsp_i.rvalid && owner_q;
    fetch_rsp_o.rdata  = owner_q ? mem_rsp_i.rdata : '0;
  end

  // a fetch request that lost the port stays up at the same pc
  a_fetch_held: assert property (@(posedge clk) disable iff (reset)
    (fetch_req_i.valid && !fetch_rsp_o.gnt) |=>
      (fetch_req_i.valid && $stable(fetch_req_i.addr)));

endmodule

/* logic/sram_bank.sv */
`timescale 1ns/1ps

module sram_bank
  import mem_bus_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  mem_req_t mem_req_i,
  output mem_rsp_t mem_rsp_o
);

  logic [WORD_W-1:0]     mem_q [MEM_WORDS];
  logic [31:0]           offset;
  logic [MEM_ADDR_W-1:0] word_idx;
  logic [BE_W-1:0]       wr_be;
  logic [WORD_W-1:0]     old_word, new_word;
  logic [WORD_W-1:0]     rdata_q;
  logic                  rvalid_q;

  // zero fill stands in for the reset clearing walk
  initial begin
    for (int i = 0; i < MEM_WORDS; i++) mem_q[i] = '0;
  end

  assign offset   = mem_req_i.addr - DMEM_BASE;
  assign word_idx = offset[MEM_ADDR_W+1:2];
  assign wr_be    = mem_req_i.we ? mem_req_i.be : '0;
  assign old_word = mem_q[word_idx];

  // byte merge, the result is also what a write returns
  always_comb begin
    for (int b = 0; b < BE_W; b++) begin
      new_word[8*b +: 8] = wr_be[b] ? mem_req_i.wdata[8*b +: 8] : old_word[8*b +: 8];
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req_i.valid) begin
      if (mem_req_i.we) mem_q[word_idx] <= new_word;
      rdata_q <= new_word;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) rvalid_q <= 1'b0;
    else       rvalid_q <= mem_req_i.valid;  // every grant answers next cycle
  end

  assign mem_rsp_o.gnt    = mem_req_i.valid;  // single port, never busy
  assign mem_rsp_o.rvalid = rvalid_q;
  assign mem_rsp_o.rdata  = rdata_q;

endmodule

/* logic/lsu_subsystem.sv */
`timescale 1ns/1ps

module lsu_subsystem
  import mem_bus_pkg::*;
  import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  lsu_cmd_t    cmd_i,
  output logic        stall_o,
  output logic        load_done_o,
  output logic [31:0] load_data_o,
  input  logic        fetch_en_i,
  output logic        instr_valid_o,
  output logic [31:0] instr_o,
  output logic [31:0] instr_pc_o
);

  mem_req_t data_req, fetch_req, sram_req;
  mem_rsp_t data_rsp, fetch_rsp, sram_rsp;

  lsu_core lsu_core_i (
    .clk         (clk),
    .reset       (reset),
    .cmd_i       (cmd_i),
    .stall_o     (stall_o),
    .load_done_o (load_done_o),
    .load_data_o (load_data_o),
    .mem_req_o   (data_req),
    .mem_rsp_i   (data_rsp)
  );

  fetch_unit fetch_unit_i (
    .clk           (clk),
    .reset         (reset),
    .fetch_en_i    (fetch_en_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o),
    .mem_req_o     (fetch_req),
    .mem_rsp_i     (fetch_rsp)
  );

  // data ahead of fetch on the shared port
  mem_arbiter mem_arbiter_i (
    .clk         (clk),
    .reset       (reset),
    .data_req_i  (data_req),
    .fetch_req_i (fetch_req),
    .data_rsp_o  (data_rsp),
    .fetch_rsp_o (fetch_rsp),
    .mem_req_o   (sram_req),
    .mem_rsp_i   (sram_rsp)
  );

  sram_bank sram_bank_i (
    .clk       (clk),
    .reset     (reset),
    .mem_req_i (sram_req),
    .mem_rsp_o (sram_rsp)
  );

endmodule

/* testbench/tb_vectors.svh */
// columns: name, op, byte offset from DMEM_BASE, store data, expected load data
// stores ignore the last column, memory starts out all zero
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

function automatic void fill_vector_table();
  add_vector("lw_zero",  OP_LW,   32'h40, 32'h0000_0000, 32'h0000_0000);
  add_vector("sw_w0",    OP_SW,   32'h00, 32'h1234_5678, 32'h0000_0000);
  add_vector("sw_w1",    OP_SW,   32'h04, 32'hdead_beef, 32'h0000_0000);
  add_vector("lw_w0",    OP_LW,   32'h00, 32'h0000_0000, 32'h1234_5678);
  add_vector("lw_w1",    OP_LW,   32'h04, 32'h0000_0000, 32'hdead_beef);
  add_vector("sb_l0",    OP_SB,   32'h10, 32'haaaa_aa81, 32'h0000_0000);
  add_vector("lw_sb0",   OP_LW,   32'h10, 32'h0000_0000, 32'h0000_0081);
  add_vector("sb_l1",    OP_SB,   32'h11, 32'h5555_5542, 32'h0000_0000);
  add_vector("sb_l2",    OP_SB,   32'h12, 32'h0000_00f3, 32'h0000_0000);
  add_vector("sb_l3",    OP_SB,   32'h13, 32'h1234_5607, 32'h0000_0000);
  add_vector("lw_bytes", OP_LW,   32'h10, 32'h0000_0000, 32'h07f3_4281);
  add_vector("lb_l0",    OP_LB,   32'h10, 32'h0000_0000, 32'hffff_ff81);
  add_vector("lbu_l0",   OP_LBU,  32'h10, 32'h0000_0000, 32'h0000_0081);
  add_vector("lb_l1",    OP_LB,   32'h11, 32'h0000_0000, 32'h0000_0042);
  add_vector("lbu_l2",   OP_LBU,  32'h12, 32'h0000_0000, 32'h0000_00f3);
  add_vector("lb_w1_l3", OP_LB,   32'h07, 32'h0000_0000, 32'hffff_ffde);
  add_vector("sh_lo",    OP_SH,   32'h20, 32'hffff_8a5c, 32'h0000_0000);
  add_vector("sh_hi",    OP_SH,   32'h22, 32'h0000_7e01, 32'h0000_0000);
  add_vector("lw_halves", OP_LW,  32'h20, 32'h0000_0000, 32'h7e01_8a5c);
  add_vector("lh_lo",    OP_LH,   32'h20, 32'h0000_0000, 32'hffff_8a5c);
  add_vector("lhu_lo",   OP_LHU,  32'h20, 32'h0000_0000, 32'h0000_8a5c);
  add_vector("lhu_hi",   OP_LHU,  32'h22, 32'h0000_0000, 32'h0000_7e01);
  add_vector("lh_w1",    OP_LH,   32'h06, 32'h0000_0000, 32'hffff_dead);
  add_vector("none",     OP_NONE, 32'h00, 32'h0000_0000, 32'h0000_0000);
endfunction

`endif

/* testbench/tb_lsu_subsystem.sv */
`timescale 1ns/1ps

module tb_lsu_subsystem
  import mem_bus_pkg::*;
  import lsu_pkg::*;
();

  localparam int N_RAND = 24;  // random rows with fetch running

  logic        clk, reset, fetch_en_i;
  lsu_cmd_t    cmd_i;
  logic        stall_o, load_done_o, instr_valid_o;
  logic [31:0] load_data_o, instr_o, instr_pc_o;

  logic [31:0] model_mem [MEM_WORDS];
  logic        dirty [MEM_WORDS];  // stored to while fetch runs alongside
  logic        track_dirty = 1'b0;
  logic [31:0] fetch_pc = DMEM_BASE;  // pc the next fetched word must carry
  int          errors = 0, checks = 0, fetch_count = 0, cycles = 0, cycle_limit = 0;

  string       vec_name[$];
  lsu_op_e     vec_op[$];
  logic [31:0] vec_off[$], vec_wdata[$], vec_exp[$];

  lsu_subsystem lsu_subsystem_i (
    .clk           (clk),
    .reset         (reset),
    .cmd_i         (cmd_i),
    .stall_o       (stall_o),
    .load_done_o   (load_done_o),
    .load_data_o   (load_data_o),
    .fetch_en_i    (fetch_en_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_pc_o    (instr_pc_o)
  );

  always #20 clk = ~clk;

  function automatic void add_vector(string name, lsu_op_e op, logic [31:0] off,
                                     logic [31:0] wdata, logic [31:0] exp_data);
    vec_name.push_back(name);
    vec_op.push_back(op);
    vec_off.push_back(off);
    vec_wdata.push_back(wdata);
    vec_exp.push_back(exp_data);
  endfunction

  `include "tb_vectors.svh"

  function automatic int word_index(logic [31:0] addr);
    logic [31:0] off;
    off = addr - DMEM_BASE;
    return int'(off[MEM_ADDR_W+1:2]);
  endfunction

  // lane rules, little endian, low address bits pick the byte or half
  function automatic void store_to_model(lsu_op_e op, logic [31:0] addr, logic [31:0] data);
    int w;
    w = word_index(addr);
    case (op)
      OP_SB:   model_mem[w][8*addr[1:0] +: 8] = data[7:0];
      OP_SH:   model_mem[w][16*addr[1] +: 16] = data[15:0];
      OP_SW:   model_mem[w] = data;
      default: ;
    endcase
  endfunction

  function automatic logic [31:0] load_from_model(lsu_op_e op, logic [31:0] addr);
    logic [31:0] w;
    logic [7:0]  b;
    logic [15:0] h;
    w = model_mem[word_index(addr)];
    b = w[8*addr[1:0] +: 8];
    h = w[16*addr[1] +: 16];
    case (op)
      OP_LB:   return {{24{b[7]}}, b};
      OP_LBU:  return {24'h0, b};
      OP_LH:   return {{16{h[15]}}, h};
      OP_LHU:  return {16'h0, h};
      default: return w;
    endcase
  endfunction

  // entered and left at the drive point, 2 ns after a rising edge
  task automatic issue_command(input string name, input lsu_op_e op, input logic [31:0] off,
                               input logic [31:0] wdata, input logic [31:0] exp_data);
    logic ld, st;
    ld = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    st = op inside {OP_SB, OP_SH, OP_SW};
    cmd_i.op    = op;
    cmd_i.addr  = DMEM_BASE + off;
    cmd_i.wdata = wdata;
    @(negedge clk);
    checks++;
    if (stall_o !== (ld || st)) begin
      errors++;
      $display("Mismatch %s stall_o: expected %b, actual %b", name, ld || st, stall_o);
    end
    while (stall_o === 1'b1) @(negedge clk);  // held until read-valid
    checks++;
    if (load_done_o !== ld) begin
      errors++;
      $display("Mismatch %s load_done_o: expected %b, actual %b", name, ld, load_done_o);
    end
    if (ld && load_data_o !== exp_data) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp_data, load_data_o);
    end
    if (st) begin
      store_to_model(op, cmd_i.addr, wdata);
      if (track_dirty) dirty[word_index(cmd_i.addr)] = 1'b1;
    end
    @(posedge clk);
    #2;
    cmd_i.op = OP_NONE;  // pipeline moves on
  endtask

  // every fetched word in pc order, against the model
  always @(negedge clk) begin
    if (!reset && instr_valid_o) begin
      checks++;
      if (instr_pc_o !== fetch_pc) begin
        errors++;
        $display("Mismatch fetch_pc: expected %h, actual %h", fetch_pc, instr_pc_o);
      end
      if (!dirty[word_index(fetch_pc)] && instr_o !== model_mem[word_index(fetch_pc)]) begin
        errors++;
        $display("Mismatch fetch_%h: expected %h, actual %h", fetch_pc,
                 model_mem[word_index(fetch_pc)], instr_o);
      end
      fetch_pc = fetch_pc + 32'd4;
      fetch_count++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped answering, errors %0d",
               cycles, errors);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    lsu_op_e     op;
    logic [31:0] off, wdata;
    int          seen;
    clk        = 1'b0;
    reset      = 1'b1;
    fetch_en_i = 1'b0;
    cmd_i      = '0;
    void'($urandom(4));
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = '0;
      dirty[i]     = 1'b0;
    end
    fill_vector_table();
    cycle_limit = 40 * (vec_name.size() + N_RAND) + 400;
    repeat (8) @(posedge clk);
    #2;
    reset = 1'b0;

    foreach (vec_name[i])
      issue_command(vec_name[i], vec_op[i], vec_off[i], vec_wdata[i], vec_exp[i]);

    // fetch alone, pcs from DMEM_BASE upward
    fetch_en_i = 1'b1;
    while (fetch_count < 6) @(posedge clk);
    #2;

    // loads and stores racing the still running fetch unit for the port
    track_dirty = 1'b1;
    seen        = fetch_count;
    for (int i = 0; i < N_RAND; i++) begin
      op  = lsu_op_e'(4'($urandom_range(1, 8)));
      off = 32'($urandom_range(0, 15)) * 32'd4;
      case (op)
        OP_LB, OP_LBU, OP_SB: off = off + $urandom_range(0, 3);
        OP_LH, OP_LHU, OP_SH: off = off + 2 * $urandom_range(0, 1);
        default: ;
      endcase
      wdata = $urandom;
      issue_command($sformatf("rand%0d_%s", i, op.name()), op, off, wdata,
                    load_from_model(op, DMEM_BASE + off));
    end
    fetch_en_i = 1'b0;
    if (fetch_count == seen) begin
      errors++;
      $display("fetch returned no words while loads and stores were running");
    end
    repeat (4) @(posedge clk);

    $display("checks %0d, errors %0d, fetched words %0d", checks, errors, fetch_count);
    if (errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* sim.f */
+incdir+testbench
logic/mem_bus_pkg.sv
logic/lsu_pkg.sv
logic/lsu_core.sv
logic/fetch_unit.sv
logic/mem_arbiter.sv
logic/sram_bank.sv
logic/lsu_subsystem.sv
testbench/tb_lsu_subsystem.sv

/* run.sh */
#!/bin/sh
# build with verilator, run, then look for the fail line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_lsu_subsystem \
  -Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_lsu_subsystem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '\*\* FAIL \*\*' sim.log; then
  exit 1
fi
exit 0
